// ==== vlog.f ====
hw/mm_cfg_pkg.sv
hw/mm_types_pkg.sv
hw/operand_ram.sv
hw/operand_loader.sv
hw/skew_feeder.sv
hw/mac_cell.sv
hw/systolic_grid.sv
hw/result_readout.sv
hw/matrix_mult_top.sv
verification/tb_matrix_mult.sv

// ==== verification/tb_matrix_mult.sv ====
module tb_matrix_mult;

  timeunit 1ns;
  timeprecision 1ps;

  import mm_cfg_pkg::*;
  import mm_types_pkg::*;

  localparam int RESET_CYCLES = 8;
  // budget per run covers the writes, the run and the readout
  localparam int RUNS = 6;
  localparam int WRITE_CYCLES = 2 * MAT_ELEMS;
  localparam int RUN_WAIT = 25;
  localparam int READ_CYCLES = 24;
  localparam int MARGIN = 100;
  localparam int TIMEOUT_CYCLES = RUNS * (WRITE_CYCLES + RUN_WAIT + READ_CYCLES) + MARGIN;

  logic    clk;
  logic    reset;
  ram_wr_t i_wr;
  logic    i_start;
  addr_t   i_out_sel;
  acc_t    o_data_out;
  logic    o_done;

  int    seed;
  int    cycle_count;
  int    test_errors;
  int    pass_count;
  int    fail_count;
  string current_test;
  acc_t  held;

  // host-side copies of both operand RAMs
  elem_t model_a [MAT_ELEMS];
  elem_t model_b [MAT_ELEMS];

  matrix_mult_top matrix_mult_top_inst (
    .clk        (clk),
    .reset      (reset),
    .i_wr       (i_wr),
    .i_start    (i_start),
    .i_out_sel  (i_out_sel),
    .o_data_out (o_data_out),
    .o_done     (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles in %s, o_done never rose", cycle_count, current_test);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // C[i][j] is the sum over k of A[i][k] * B[k][j] wrapped to 32 bits
  function automatic acc_t model_result(input int idx);
    int   row;
    int   col;
    acc_t sum;
    row = idx / MAT_N;
    col = idx % MAT_N;
    sum = '0;
    for (int k = 0; k < MAT_N; k++) begin
      sum = sum + acc_t'(model_a[row * MAT_N + k]) * acc_t'(model_b[k * MAT_N + col]);
    end
    return sum;
  endfunction

  task automatic check_value(input string label, input acc_t expected, input acc_t actual);
    assert (actual === expected) else begin
      $display("Error: %s expected %08h actual %08h", label, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_low(input logic value, input string what);
    assert (value === 1'b0) else begin
      $display("Error: %s %s expected 0 actual %b", current_test, what, value);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    current_test = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %s: ok", current_test);
      pass_count++;
    end else begin
      $display("test %s: %0d mismatches", current_test, test_errors);
      fail_count++;
    end
  endtask

  task automatic write_elem(input logic to_b, input int idx, input elem_t value);
    @(negedge clk);
    i_wr.we_a = !to_b;
    i_wr.we_b = to_b;
    i_wr.addr = addr_t'(idx);
    i_wr.data = value;
    if (to_b) begin
      model_b[idx] = value;
    end else begin
      model_a[idx] = value;
    end
  endtask

  task automatic load_random(input logic to_b);
    elem_t value;
    for (int idx = 0; idx < MAT_ELEMS; idx++) begin
      value = elem_t'($random(seed));
      write_elem(to_b, idx, value);
    end
  endtask

  task automatic load_constant(input logic to_b, input elem_t value);
    for (int idx = 0; idx < MAT_ELEMS; idx++) begin
      write_elem(to_b, idx, value);
    end
  endtask

  // one idle cycle lets the last write land before the loader takes the address
  task automatic run_and_wait();
    @(negedge clk);
    i_wr.we_a = 1'b0;
    i_wr.we_b = 1'b0;
    @(negedge clk);
    i_start = 1'b1;
    @(negedge clk);
    while (!o_done) begin
      @(negedge clk);
    end
  endtask

  // result shows one cycle after the select
  task automatic read_check(input int sel, input acc_t expected);
    i_out_sel = addr_t'(sel);
    @(negedge clk);
    check_value($sformatf("%s sel %0d", current_test, sel), expected, o_data_out);
  endtask

  task automatic check_all();
    for (int idx = 0; idx < MAT_ELEMS; idx++) begin
      read_check(idx, model_result(idx));
    end
  endtask

  task automatic end_run();
    i_start = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    reset = 1'b1;
    i_start = 1'b0;
    i_wr = '0;
    i_out_sel = '0;
    seed = 32'hbf67;
    cycle_count = 0;
    pass_count = 0;
    fail_count = 0;
    current_test = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    begin_test("control_levels");
    check_low(o_done, "o_done after reset");
    check_value("control_levels reset", '0, o_data_out);
    load_random(1'b0);
    load_random(1'b1);
    run_and_wait();
    read_check(4, model_result(4));
    end_run();
    check_low(o_done, "o_done one cycle after start dropped");
    // last selected result stays on the output
    held = model_result(4);
    for (int sel = 0; sel < RAM_DEPTH; sel++) begin
      i_out_sel = addr_t'(sel);
      @(negedge clk);
      check_value($sformatf("%s hold sel %0d", current_test, sel), held, o_data_out);
    end
    finish_test();

    begin_test("random_product");
    load_random(1'b0);
    load_random(1'b1);
    run_and_wait();
    check_all();
    end_run();
    finish_test();

    // B stays so stale sums would show up here
    begin_test("partial_reload");
    load_random(1'b0);
    run_and_wait();
    check_all();
    end_run();
    finish_test();

    begin_test("largest_operands");
    load_constant(1'b0, 16'hffff);
    load_constant(1'b1, 16'hffff);
    run_and_wait();
    check_all();
    end_run();
    finish_test();

    begin_test("out_of_range_select");
    load_random(1'b0);
    load_random(1'b1);
    run_and_wait();
    for (int sel = MAT_ELEMS; sel < RAM_DEPTH; sel++) begin
      read_check(sel, model_result(MAT_ELEMS - 1));
    end
    end_run();
    finish_test();

    $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hw/matrix_mult_top.sv ====
module matrix_mult_top (
  input  logic                   clk,
  input  logic                   reset,
  input  mm_types_pkg::ram_wr_t  i_wr,
  input  logic                   i_start,
  input  mm_types_pkg::addr_t    i_out_sel,
  output mm_types_pkg::acc_t     o_data_out,
  output logic                   o_done
);

  import mm_types_pkg::*;

  addr_t   ram_addr;
  elem_t   q_a;
  elem_t   q_b;
  logic    we_a_q;
  logic    we_b_q;
  elem_t   wr_data_q;
  matrix_t mat_a;
  matrix_t mat_b;
  logic    loaded;
  edge_t   edge_feed;
  logic    clear;
  result_t results;

  // loader registers the address, so strobe and data follow one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      we_a_q <= 1'b0;
      we_b_q <= 1'b0;
    end else begin
      we_a_q <= i_wr.we_a & ~i_start;
      we_b_q <= i_wr.we_b & ~i_start;
    end
  end

  always_ff @(posedge clk) begin
    wr_data_q <= i_wr.data;
  end

  operand_ram ram_a_inst (
    .clk    (clk),
    .i_addr (ram_addr),
    .i_data (wr_data_q),
    .i_we   (we_a_q),
    .o_q    (q_a)
  );

  operand_ram ram_b_inst (
    .clk    (clk),
    .i_addr (ram_addr),
    .i_data (wr_data_q),
    .i_we   (we_b_q),
    .o_q    (q_b)
  );

  operand_loader operand_loader_inst (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_wr_addr (i_wr.addr),
    .i_q_a     (q_a),
    .i_q_b     (q_b),
    .o_rd_addr (ram_addr),
    .o_mat_a   (mat_a),
    .o_mat_b   (mat_b),
    .o_loaded  (loaded)
  );

  skew_feeder skew_feeder_inst (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .i_loaded (loaded),
    .i_mat_a  (mat_a),
    .i_mat_b  (mat_b),
    .o_edge   (edge_feed),
    .o_clear  (clear),
    .o_done   (o_done)
  );

  systolic_grid systolic_grid_inst (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_edge    (edge_feed),
    .o_results (results)
  );

  result_readout result_readout_inst (
    .clk        (clk),
    .reset      (reset),
    .i_done     (o_done),
    .i_out_sel  (i_out_sel),
    .i_results  (results),
    .o_data_out (o_data_out)
  );

endmodule

// ==== hw/result_readout.sv ====
module result_readout (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_done,
  input  mm_types_pkg::addr_t    i_out_sel,
  input  mm_types_pkg::result_t  i_results,
  output mm_types_pkg::acc_t     o_data_out
);

  import mm_types_pkg::*;

  // holds its value whenever done is low
  always_ff @(posedge clk) begin
    if (reset) begin
      o_data_out <= '0;
    end else if (i_done) begin
      case (i_out_sel)
        4'd0: o_data_out <= i_results.c00;
        4'd1: o_data_out <= i_results.c01;
        4'd2: o_data_out <= i_results.c02;
        4'd3: o_data_out <= i_results.c10;
        4'd4: o_data_out <= i_results.c11;
        4'd5: o_data_out <= i_results.c12;
        4'd6: o_data_out <= i_results.c20;
        4'd7: o_data_out <= i_results.c21;
        // 8 and every unused index
        default: o_data_out <= i_results.c22;
      endcase
    end
  end

endmodule

// ==== hw/systolic_grid.sv ====
module systolic_grid (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_clear,
  input  mm_types_pkg::edge_t    i_edge,
  output mm_types_pkg::result_t  o_results
);

  import mm_cfg_pkg::*;
  import mm_types_pkg::*;

  // a moves right along a row, b moves down a column
  elem_t a_link [MAT_N][MAT_N+1];
  elem_t b_link [MAT_N+1][MAT_N];
  acc_t  cell_acc [MAT_N][MAT_N];

  for (genvar r = 0; r < MAT_N; r++) begin : g_row
    assign a_link[r][0] = i_edge.a_row[r];
  end

  for (genvar c = 0; c < MAT_N; c++) begin : g_col_edge
    assign b_link[0][c] = i_edge.b_col[c];
  end

  for (genvar r = 0; r < MAT_N; r++) begin : g_mesh_row
    for (genvar c = 0; c < MAT_N; c++) begin : g_mesh_col
      mac_cell mac_cell_inst (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_acc   (cell_acc[r][c])
      );
    end
  end

  // pack row-major, c00 in the top bits
  always_comb begin
    o_results = '0;
    for (int r = 0; r < MAT_N; r++) begin
      for (int c = 0; c < MAT_N; c++) begin
        o_results[(MAT_ELEMS - 1 - (r * MAT_N + c)) * ACC_W +: ACC_W] = cell_acc[r][c];
      end
    end
  end

endmodule

// ==== hw/mac_cell.sv ====
module mac_cell (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  mm_types_pkg::elem_t  i_a,
  input  mm_types_pkg::elem_t  i_b,
  output mm_types_pkg::elem_t  o_a,
  output mm_types_pkg::elem_t  o_b,
  output mm_types_pkg::acc_t   o_acc
);

  import mm_types_pkg::*;

  // operands hop one cell per cycle, unchanged
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // full 32-bit product, sum wraps mod 2^32
  always_ff @(posedge clk) begin
    if (reset) begin
      o_acc <= '0;
    end else if (i_clear) begin
      o_acc <= '0;
    end else begin
      o_acc <= o_acc + acc_t'(i_a) * acc_t'(i_b);
    end
  end

endmodule

// ==== hw/skew_feeder.sv ====
module skew_feeder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  logic                   i_loaded,
  input  mm_types_pkg::matrix_t  i_mat_a,
  input  mm_types_pkg::matrix_t  i_mat_b,
  output mm_types_pkg::edge_t    o_edge,
  output logic                   o_clear,
  output logic                   o_done
);

  import mm_cfg_pkg::*;
  import mm_types_pkg::*;

  localparam int STEP_W = $clog2(RUN_CYCLES + 1);

  logic              started;
  logic [STEP_W-1:0] step;
  elem_t             a_arr [MAT_N][MAT_N];
  elem_t             b_arr [MAT_N][MAT_N];
  edge_t             next_edge;

  // first cycle with both matrices captured
  assign o_clear = i_loaded && !started;

  // flatten struct fields into indexable grids
  always_comb begin
    for (int r = 0; r < MAT_N; r++) begin
      for (int c = 0; c < MAT_N; c++) begin
        a_arr[r][c] = i_mat_a[(MAT_ELEMS - 1 - (r * MAT_N + c)) * ELEM_W +: ELEM_W];
        b_arr[r][c] = i_mat_b[(MAT_ELEMS - 1 - (r * MAT_N + c)) * ELEM_W +: ELEM_W];
      end
    end
  end

  // row i gets A[i][k-i] and column j gets B[k-j][j] on the diagonal wavefront
  always_comb begin
    int k;
    k = int'(step);
    next_edge = '0;
    for (int i = 0; i < MAT_N; i++) begin
      if (k < FEED_STEPS && k - i >= 0 && k - i < MAT_N) begin
        next_edge.a_row[i] = a_arr[i][k - i];
        next_edge.b_col[i] = b_arr[k - i][i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      step    <= '0;
      o_edge  <= '0;
      o_done  <= 1'b0;
    end else if (!i_start) begin
      started <= 1'b0;
      step    <= '0;
      o_edge  <= '0;
      o_done  <= 1'b0;
    end else if (o_clear) begin
      started <= 1'b1;
      step    <= STEP_W'(1);
      o_edge  <= next_edge;
    end else if (started) begin
      // zeros flow in once the feed steps run out
      o_edge <= next_edge;
      if (step < RUN_CYCLES) begin
        step <= step + 1'b1;
      end
      if (step == RUN_CYCLES) begin
        o_done <= 1'b1;
      end
    end
  end

  a_done_needs_loaded: assert property (
    @(posedge clk) disable iff (reset)
    o_done |-> i_loaded
  );

  a_clear_single: assert property (
    @(posedge clk) disable iff (reset)
    o_clear |=> !o_clear
  );

endmodule

// ==== hw/operand_loader.sv ====
module operand_loader (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  mm_types_pkg::addr_t    i_wr_addr,
  input  mm_types_pkg::elem_t    i_q_a,
  input  mm_types_pkg::elem_t    i_q_b,
  output mm_types_pkg::addr_t    o_rd_addr,
  output mm_types_pkg::matrix_t  o_mat_a,
  output mm_types_pkg::matrix_t  o_mat_b,
  output logic                   o_loaded
);

  import mm_cfg_pkg::*;
  import mm_types_pkg::*;

  localparam addr_t LAST_ADDR = addr_t'(MAT_ELEMS - 1);

  // start seen on the previous edge
  logic  running;
  // address whose data the ram presents this cycle
  addr_t cap_addr;
  logic  cap_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      running   <= 1'b0;
      o_rd_addr <= '0;
      cap_addr  <= '0;
      cap_valid <= 1'b0;
      o_loaded  <= 1'b0;
    end else if (!i_start) begin
      // host owns the address between runs
      running   <= 1'b0;
      o_rd_addr <= i_wr_addr;
      cap_valid <= 1'b0;
      o_loaded  <= 1'b0;
    end else begin
      running   <= 1'b1;
      cap_addr  <= o_rd_addr;
      cap_valid <= running;
      if (!running) begin
        o_rd_addr <= '0;
      end else if (o_rd_addr < LAST_ADDR) begin
        o_rd_addr <= o_rd_addr + 1'b1;
      end
      if (cap_valid && cap_addr == LAST_ADDR) begin
        o_loaded <= 1'b1;
      end
    end
  end

  // one ram word per matrix lands in its slot each cycle
  always_ff @(posedge clk) begin
    if (i_start && cap_valid) begin
      case (cap_addr)
        4'd0: begin o_mat_a.m00 <= i_q_a; o_mat_b.m00 <= i_q_b; end
        4'd1: begin o_mat_a.m01 <= i_q_a; o_mat_b.m01 <= i_q_b; end
        4'd2: begin o_mat_a.m02 <= i_q_a; o_mat_b.m02 <= i_q_b; end
        4'd3: begin o_mat_a.m10 <= i_q_a; o_mat_b.m10 <= i_q_b; end
        4'd4: begin o_mat_a.m11 <= i_q_a; o_mat_b.m11 <= i_q_b; end
        4'd5: begin o_mat_a.m12 <= i_q_a; o_mat_b.m12 <= i_q_b; end
        4'd6: begin o_mat_a.m20 <= i_q_a; o_mat_b.m20 <= i_q_b; end
        4'd7: begin o_mat_a.m21 <= i_q_a; o_mat_b.m21 <= i_q_b; end
        4'd8: begin o_mat_a.m22 <= i_q_a; o_mat_b.m22 <= i_q_b; end
        default: begin
          o_mat_a.m22 <= o_mat_a.m22;
          o_mat_b.m22 <= o_mat_b.m22;
        end
      endcase
    end
  end

  // counter never walks past the last element during a run
  a_rd_addr_range: assert property (
    @(posedge clk) disable iff (reset)
    i_start && running |-> o_rd_addr <= LAST_ADDR
  );

endmodule

// ==== hw/operand_ram.sv ====
module operand_ram (
  input  logic                 clk,
  input  mm_types_pkg::addr_t  i_addr,
  input  mm_types_pkg::elem_t  i_data,
  input  logic                 i_we,
  output mm_types_pkg::elem_t  o_q
);

  mm_types_pkg::elem_t mem [mm_cfg_pkg::RAM_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_data;
    end
  end

  // registered read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    o_q <= mem[i_addr];
  end

endmodule

// ==== hw/mm_types_pkg.sv ====
package mm_types_pkg;

  import mm_cfg_pkg::*;

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [ACC_W-1:0] acc_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // host write port, one strobe per matrix
  typedef struct packed {
    logic we_a;
    logic we_b;
    addr_t addr;
    elem_t data;
  } ram_wr_t;

  // row-major, m00 sits in the top bits
  typedef struct packed {
    elem_t m00, m01, m02;
    elem_t m10, m11, m12;
    elem_t m20, m21, m22;
  } matrix_t;

  // values entering the left and top edges in one cycle
  typedef struct packed {
    elem_t [MAT_N-1:0] a_row;
    elem_t [MAT_N-1:0] b_col;
  } edge_t;

  typedef struct packed {
    acc_t c00, c01, c02;
    acc_t c10, c11, c12;
    acc_t c20, c21, c22;
  } result_t;

endpackage

// ==== hw/mm_cfg_pkg.sv ====
package mm_cfg_pkg;

  // matrix geometry
  localparam int MAT_N = 3;
  localparam int MAT_ELEMS = MAT_N * MAT_N;

  // datapath widths
  localparam int ELEM_W = 16;
  localparam int ACC_W = 2 * ELEM_W;

  // operand ram
  localparam int ADDR_W = 4;
  localparam int RAM_DEPTH = 16;

  // live edge data spans the skewed diagonal
  localparam int FEED_STEPS = 2 * MAT_N - 1;

  // clear to done, leaves room for the last cell to drain
  localparam int RUN_CYCLES = 3 * MAT_N;

endpackage
